/* decodePipeTop.f */
logic/corePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/issueStage.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/decodePipeTop.sv
tests/pipeChecker.sv
tests/tbDecodePipe.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbDecodePipe -f decodePipeTop.f

output=$(./obj_dir/VtbDecodePipe || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

/* tests/tbDecodePipe.sv */
module tbDecodePipe;
    import corePkg::*;

    logic        clk = 1'b0;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instrWord;
    logic        instrCredit;
    logic        resValid;
    logic [4:0]  resReg;
    logic [31:0] resData;
    logic        resIllegal;
    logic        resCreditReturn = 1'b0;
    logic [3:0]  sendTest;
    logic        sendLast;
    logic        endRun;
    logic        allReported;
    int          errorTotal;
    int          testsFailed;

    logic [31:0] words [$];
    int          rowTest [$];
    int          cycles;
    int          cycleLimit;
    bit          timedOut;
    int          returnDue [$];
    int          returnsOwed;

    always #5 clk = ~clk;

    decodePipeTop i_decodePipeTop (
        .clk             (clk),
        .arstN           (arstN),
        .instrValid      (instrValid),
        .instrWord       (instrWord),
        .instrCredit     (instrCredit),
        .resValid        (resValid),
        .resReg          (resReg),
        .resData         (resData),
        .resIllegal      (resIllegal),
        .resCreditReturn (resCreditReturn)
    );

    pipeChecker i_pipeChecker (
        .clk             (clk),
        .arstN           (arstN),
        .instrValid      (instrValid),
        .instrWord       (instrWord),
        .sendTest        (sendTest),
        .sendLast        (sendLast),
        .instrCredit     (instrCredit),
        .resValid        (resValid),
        .resReg          (resReg),
        .resData         (resData),
        .resIllegal      (resIllegal),
        .resCreditReturn (resCreditReturn),
        .endRun          (endRun),
        .allReported     (allReported),
        .errorTotal      (errorTotal),
        .testsFailed     (testsFailed)
    );

    // rd, rs, rt in assembly order
    function automatic logic [31:0] rType(functT fn, int rd, int rs, int rt, int sh);
        return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] iType(opcodeT op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic addRow(input int test, input logic [31:0] word);
        rowTest.push_back(test);
        words.push_back(word);
    endtask

    task automatic buildTable();
        // zero registers after reset
        addRow(1, rType(fnAddu, 1, 5, 6, 0));
        addRow(1, rType(fnAddu, 2, 7, 8, 0));
        // one of each operation
        addRow(2, iType(opOri, 3, 0, 'h1234));
        addRow(2, iType(opLui, 4, 0, 'habcd));
        addRow(2, rType(fnAddu, 5, 3, 4, 0));
        addRow(2, rType(fnSubu, 6, 3, 4, 0));
        addRow(2, rType(fnSll, 7, 0, 3, 4));
        addRow(2, rType(fnSlt, 8, 6, 3, 0));
        addRow(2, rType(fnSlt, 9, 3, 6, 0));
        // dependency chain on r10
        addRow(3, iType(opOri, 10, 0, 1));
        addRow(3, rType(fnAddu, 10, 10, 10, 0));
        addRow(3, rType(fnAddu, 10, 10, 10, 0));
        addRow(3, rType(fnSll, 11, 0, 10, 3));
        addRow(3, rType(fnSubu, 12, 11, 10, 0));
        addRow(3, iType(opOri, 12, 12, 'hf0));
        // burst against slow credit returns
        for (int i = 0; i < 10; i++) begin
            addRow(4, iType(opOri, 13 + i % 4, 0, int'($urandom % 65536)));
        end
        addRow(4, rType(fnAddu, 17, 13, 14, 0));
        addRow(4, rType(fnSubu, 18, 15, 16, 0));
        // unknown words and nops
        addRow(5, 32'hffff_ffff);
        addRow(5, {6'h00, 5'd3, 5'd4, 5'd20, 5'd0, 6'h3f});
        addRow(5, {6'h23, 5'd0, 5'd3, 16'h0010});
        addRow(5, 32'd0);
        addRow(5, 32'd0);
        addRow(5, rType(fnAddu, 21, 3, 20, 0));
        // writes to r0
        addRow(6, iType(opOri, 0, 3, 'h55));
        addRow(6, rType(fnAddu, 0, 3, 4, 0));
        addRow(6, iType(opLui, 0, 0, 'hffff));
        addRow(6, rType(fnAddu, 23, 0, 3, 0));
    endtask

    // echo each result credit after 0 to 6 cycles
    always @(posedge clk) begin
        int i;
        if (resValid === 1'b1) begin
            returnDue.push_back(cycles + int'($urandom % 7));
        end
        for (i = returnDue.size() - 1; i >= 0; i--) begin
            if (returnDue[i] <= cycles) begin
                returnsOwed++;
                returnDue.delete(i);
            end
        end
        if (returnsOwed > 0) begin
            resCreditReturn <= 1'b1;
            returnsOwed--;
        end else begin
            resCreditReturn <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (arstN === 1'b1 && !timedOut) begin
            cycles <= cycles + 1;
            if (cycles >= cycleLimit) begin
                $display("timeout: run reached %0d cycles before all results arrived", cycleLimit);
                timedOut <= 1'b1;
            end
        end
    end

    initial begin
        int row;
        int credits;
        void'($urandom(32'h76ad_ca1b));
        arstN      = 1'b0;
        instrValid = 1'b0;
        instrWord  = 32'd0;
        sendTest   = 4'd0;
        sendLast   = 1'b0;
        endRun     = 1'b0;
        buildTable();
        cycleLimit = 10 * words.size() + 50;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        // quiet cycles before the first word
        repeat (4) @(posedge clk);
        row     = 0;
        credits = INSTR_CREDITS;
        while (row < words.size() && !timedOut) begin
            @(posedge clk);
            if (instrCredit) begin
                credits++;
            end
            if (credits > 0) begin
                instrValid <= 1'b1;
                instrWord  <= words[row];
                sendTest   <= 4'(rowTest[row]);
                sendLast   <= (row == words.size() - 1) || (rowTest[row + 1] != rowTest[row]);
                credits--;
                row++;
            end else begin
                instrValid <= 1'b0;
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        while (!allReported && !timedOut) begin
            @(posedge clk);
        end
        // let the last queue credits come back
        repeat (4) @(posedge clk);
        endRun <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        if (!timedOut && errorTotal == 0 && testsFailed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tests/pipeChecker.sv */
module pipeChecker (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid,
    input  logic [31:0] instrWord,
    input  logic [3:0]  sendTest,
    input  logic        sendLast,
    input  logic        instrCredit,
    input  logic        resValid,
    input  logic [4:0]  resReg,
    input  logic [31:0] resData,
    input  logic        resIllegal,
    input  logic        resCreditReturn,
    input  logic        endRun,
    output logic        allReported,
    output int          errorTotal,
    output int          testsFailed
);
    import corePkg::*;

    localparam int NUM_TESTS = 6;

    logic [31:0] model [32];
    int          expCount [NUM_TESTS + 1];
    int          gotCount [NUM_TESTS + 1];
    int          errCount [NUM_TESTS + 1];
    bit          closed [NUM_TESTS + 1];
    int          nextReport;
    int          testsPassed;
    int          failedTests;
    int          errors;
    int          sentWords;
    int          creditPulses;
    int          resCredits;
    bit          finished;
    int          predTest [$];
    logic [4:0]  predReg [$];
    logic [31:0] predData [$];
    logic        predIllegal [$];

    // each sent word executes at once on the reference model
    task automatic predict(input logic [31:0] word, input int test, input logic last);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [31:0] value;
        logic        legal;
        rs    = word[25:21];
        rt    = word[20:16];
        dest  = 5'd0;
        value = 32'd0;
        legal = 1'b1;
        sentWords++;
        if (word != 32'd0) begin
            case (word[31:26])
                opSpecial: begin
                    dest = word[15:11];
                    case (word[5:0])
                        fnAddu:  value = model[rs] + model[rt];
                        fnSubu:  value = model[rs] - model[rt];
                        fnSll:   value = model[rt] << word[10:6];
                        fnSlt:   value = ($signed(model[rs]) < $signed(model[rt])) ? 32'd1 : 32'd0;
                        default: legal = 1'b0;
                    endcase
                end
                opOri: begin
                    dest  = rt;
                    value = model[rs] | {16'd0, word[15:0]};
                end
                opLui: begin
                    dest  = rt;
                    value = {word[15:0], 16'd0};
                end
                default: legal = 1'b0;
            endcase
            if (!legal || dest == 5'd0) begin
                dest  = 5'd0;
                value = 32'd0;
            end else begin
                model[dest] = value;
            end
            predTest.push_back(test);
            predReg.push_back(dest);
            predData.push_back(value);
            predIllegal.push_back(!legal);
            expCount[test]++;
        end
        if (last) begin
            closed[test] = 1'b1;
        end
    endtask

    task automatic mismatch(input int test, input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
        errCount[test]++;
        errors++;
    endtask

    task automatic compareResult();
        int          test;
        logic [4:0]  expReg;
        logic [31:0] expData;
        logic        expIllegal;
        if (predTest.size() == 0) begin
            $display("time %0t: result arrived with no instruction outstanding", $time);
            errors++;
            return;
        end
        test       = predTest.pop_front();
        expReg     = predReg.pop_front();
        expData    = predData.pop_front();
        expIllegal = predIllegal.pop_front();
        gotCount[test]++;
        if (resCredits == 0) begin
            $display("time %0t: resValid asserted with no result credit left", $time);
            errCount[test]++;
            errors++;
        end else begin
            resCredits--;
        end
        if (resIllegal !== expIllegal) begin
            mismatch(test, "resIllegal", 32'(expIllegal), 32'(resIllegal));
        end
        // an illegal word has no destination to compare
        if (!expIllegal) begin
            if (resReg !== expReg) begin
                mismatch(test, "resReg", 32'(expReg), 32'(resReg));
            end
            if (resData !== expData) begin
                mismatch(test, "resData", expData, resData);
            end
        end
    endtask

    task automatic reportFinished();
        while (nextReport <= NUM_TESTS && closed[nextReport]
               && gotCount[nextReport] == expCount[nextReport]) begin
            $display("test %0d: %0d results checked, %0d errors, %s", nextReport,
                     gotCount[nextReport], errCount[nextReport],
                     (errCount[nextReport] == 0) ? "pass" : "fail");
            if (errCount[nextReport] == 0) begin
                testsPassed++;
            end else begin
                failedTests++;
            end
            nextReport++;
        end
    endtask

    task automatic finalReport();
        finished = 1'b1;
        if (predTest.size() != 0) begin
            $display("%0d expected results never arrived", predTest.size());
            errors++;
        end
        if (creditPulses != sentWords) begin
            $display("instrCredit pulsed %0d times for %0d words sent", creditPulses, sentWords);
            errors++;
        end
        while (nextReport <= NUM_TESTS) begin
            $display("test %0d did not finish", nextReport);
            failedTests++;
            nextReport++;
        end
        $display("tests passed %0d, failed %0d, errors %0d", testsPassed, failedTests, errors);
    endtask

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                model[i] = 32'd0;
            end
            for (int t = 0; t <= NUM_TESTS; t++) begin
                expCount[t] = 0;
                gotCount[t] = 0;
                errCount[t] = 0;
                closed[t]   = 1'b0;
            end
            nextReport   = 1;
            testsPassed  = 0;
            failedTests  = 0;
            errors       = 0;
            sentWords    = 0;
            creditPulses = 0;
            resCredits   = RES_CREDITS;
            finished     = 1'b0;
            allReported <= 1'b0;
        end else begin
            // outputs stay quiet until the first word goes in
            if (sentWords == 0 && (resValid || instrCredit)) begin
                $display("time %0t: output active before any instruction was sent", $time);
                errCount[1]++;
                errors++;
            end
            if (instrValid) begin
                predict(instrWord, int'(sendTest), sendLast);
            end
            if (instrCredit) begin
                creditPulses++;
            end
            if (resValid) begin
                compareResult();
            end
            resCredits = resCredits + int'(resCreditReturn);
            reportFinished();
            if (endRun && !finished) begin
                finalReport();
            end
            allReported <= (nextReport > NUM_TESTS);
            errorTotal  <= errors;
            testsFailed <= failedTests;
        end
    end

endmodule

/* logic/decodePipeTop.sv */
module decodePipeTop (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid,
    input  logic [31:0] instrWord,
    output logic        instrCredit,
    output logic        resValid,
    output logic [4:0]  resReg,
    output logic [31:0] resData,
    output logic        resIllegal,
    input  logic        resCreditReturn
);
    import corePkg::*;

    logic [4:0]  raddrA;
    logic [4:0]  raddrB;
    logic [31:0] rdataA;
    logic [31:0] rdataB;
    logic        rfWe;
    logic [4:0]  rfWaddr;
    logic [31:0] rfWdata;

    logic        exValid;
    aluOpT       exAluOp;
    aSelT        exASel;
    bSelT        exBSel;
    logic [31:0] exRsVal;
    logic [31:0] exRtVal;
    logic [4:0]  exShamt;
    logic [15:0] exImm;
    logic [4:0]  exDest;
    logic        exWrite;
    logic        exIllegal;
    logic        exStall;
    logic [4:0]  exBusyDest;
    logic        exBusyWrite;

    logic        wbValid;
    logic [4:0]  wbDest;
    logic        wbWrite;
    logic [31:0] wbData;
    logic        wbIllegal;
    logic        wbStall;

    issueStage i_issueStage (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instrWord   (instrWord),
        .instrCredit (instrCredit),
        .raddrA      (raddrA),
        .raddrB      (raddrB),
        .rdataA      (rdataA),
        .rdataB      (rdataB),
        .rfWe        (rfWe),
        .rfWaddr     (rfWaddr),
        .rfWdata     (rfWdata),
        .exStall     (exStall),
        .exBusyDest  (exBusyDest),
        .exBusyWrite (exBusyWrite),
        .exValid     (exValid),
        .exAluOp     (exAluOp),
        .exASel      (exASel),
        .exBSel      (exBSel),
        .exRsVal     (exRsVal),
        .exRtVal     (exRtVal),
        .exShamt     (exShamt),
        .exImm       (exImm),
        .exDest      (exDest),
        .exWrite     (exWrite),
        .exIllegal   (exIllegal)
    );

    executeStage i_executeStage (
        .clk         (clk),
        .arstN       (arstN),
        .exValid     (exValid),
        .exAluOp     (exAluOp),
        .exASel      (exASel),
        .exBSel      (exBSel),
        .exRsVal     (exRsVal),
        .exRtVal     (exRtVal),
        .exShamt     (exShamt),
        .exImm       (exImm),
        .exDest      (exDest),
        .exWrite     (exWrite),
        .exIllegal   (exIllegal),
        .wbStall     (wbStall),
        .exStall     (exStall),
        .exBusyDest  (exBusyDest),
        .exBusyWrite (exBusyWrite),
        .wbValid     (wbValid),
        .wbDest      (wbDest),
        .wbWrite     (wbWrite),
        .wbData      (wbData),
        .wbIllegal   (wbIllegal)
    );

    writebackStage i_writebackStage (
        .clk             (clk),
        .arstN           (arstN),
        .wbValid         (wbValid),
        .wbDest          (wbDest),
        .wbWrite         (wbWrite),
        .wbData          (wbData),
        .wbIllegal       (wbIllegal),
        .resCreditReturn (resCreditReturn),
        .wbStall         (wbStall),
        .rfWe            (rfWe),
        .rfWaddr         (rfWaddr),
        .rfWdata         (rfWdata),
        .resValid        (resValid),
        .resReg          (resReg),
        .resData         (resData),
        .resIllegal      (resIllegal)
    );

    regFile i_regFile (
        .clk    (clk),
        .arstN  (arstN),
        .raddrA (raddrA),
        .raddrB (raddrB),
        .we     (rfWe),
        .waddr  (rfWaddr),
        .wdata  (rfWdata),
        .rdataA (rdataA),
        .rdataB (rdataB)
    );

endmodule

/* logic/writebackStage.sv */
module writebackStage (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wbValid,
    input  logic [4:0]  wbDest,
    input  logic        wbWrite,
    input  logic [31:0] wbData,
    input  logic        wbIllegal,
    input  logic        resCreditReturn,
    output logic        wbStall,
    output logic        rfWe,
    output logic [4:0]  rfWaddr,
    output logic [31:0] rfWdata,
    output logic        resValid,
    output logic [4:0]  resReg,
    output logic [31:0] resData,
    output logic        resIllegal
);
    import corePkg::*;

    logic                 held;
    logic [4:0]           dest;
    logic                 write;
    logic [31:0]          data;
    logic                 illegal;
    logic [RES_CNT_W-1:0] credits;
    logic                 retire;
    logic                 take;

    assign wbStall = held && (credits == '0);
    assign retire  = held && (credits != '0);
    assign take    = wbValid && !wbStall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            held    <= 1'b0;
            credits <= RES_CNT_W'(RES_CREDITS);
        end else begin
            if (take) begin
                held <= 1'b1;
            end else if (retire) begin
                held <= 1'b0;
            end
            credits <= credits - RES_CNT_W'(retire) + RES_CNT_W'(resCreditReturn);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dest    <= wbDest;
            write   <= wbWrite;
            data    <= wbData;
            illegal <= wbIllegal;
        end
    end

    // result port and register write go out together
    assign resValid   = retire;
    assign resReg     = dest;
    assign resData    = data;
    assign resIllegal = illegal;
    assign rfWe       = retire && write;
    assign rfWaddr    = dest;
    assign rfWdata    = data;

    creditBound: assert property (
        @(posedge clk) disable iff (!arstN)
        credits <= RES_CNT_W'(RES_CREDITS)
    );

endmodule

/* logic/executeStage.sv */
module executeStage (
    input  logic           clk,
    input  logic           arstN,
    input  logic           exValid,
    input  corePkg::aluOpT exAluOp,
    input  corePkg::aSelT  exASel,
    input  corePkg::bSelT  exBSel,
    input  logic [31:0]    exRsVal,
    input  logic [31:0]    exRtVal,
    input  logic [4:0]     exShamt,
    input  logic [15:0]    exImm,
    input  logic [4:0]     exDest,
    input  logic           exWrite,
    input  logic           exIllegal,
    input  logic           wbStall,
    output logic           exStall,
    output logic [4:0]     exBusyDest,
    output logic           exBusyWrite,
    output logic           wbValid,
    output logic [4:0]     wbDest,
    output logic           wbWrite,
    output logic [31:0]    wbData,
    output logic           wbIllegal
);
    import corePkg::*;

    logic        occValid;
    aluOpT       aluOp;
    aSelT        aSel;
    bSelT        bSel;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [4:0]  shamt;
    logic [15:0] imm;
    logic [4:0]  dest;
    logic        write;
    logic        illegal;
    logic        accept;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluResult;

    assign exStall = occValid && wbStall;
    assign accept  = exValid && !exStall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            occValid <= 1'b0;
        end else if (accept) begin
            occValid <= 1'b1;
        end else if (!wbStall) begin
            occValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            aluOp   <= exAluOp;
            aSel    <= exASel;
            bSel    <= exBSel;
            rsVal   <= exRsVal;
            rtVal   <= exRtVal;
            shamt   <= exShamt;
            imm     <= exImm;
            dest    <= exDest;
            write   <= exWrite;
            illegal <= exIllegal;
        end
    end

    // zero-extend both shamt and imm
    assign opA = (aSel == aSelShamt) ? {27'd0, shamt} : rsVal;
    assign opB = (bSel == bSelImm) ? {16'd0, imm} : rtVal;

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluSll:  aluResult = opB << opA[4:0];
            aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
            aluOr:   aluResult = opA | opB;
            aluLui:  aluResult = {opB[15:0], 16'd0};
            default: aluResult = 32'd0;
        endcase
    end

    assign wbValid   = occValid;
    assign wbDest    = dest;
    assign wbWrite   = write;
    assign wbIllegal = illegal;
    assign wbData    = (write && dest != 5'd0) ? aluResult : 32'd0;

    // when empty, the last payload is the one wb still holds
    assign exBusyDest  = dest;
    assign exBusyWrite = write && (occValid || wbStall);

    noneNeverWrites: assert property (
        @(posedge clk) disable iff (!arstN)
        (exValid && exAluOp == aluNone) |-> !exWrite
    );

endmodule

/* logic/issueStage.sv */
module issueStage (
    input  logic           clk,
    input  logic           arstN,
    input  logic           instrValid,
    input  logic [31:0]    instrWord,
    output logic           instrCredit,
    output logic [4:0]     raddrA,
    output logic [4:0]     raddrB,
    input  logic [31:0]    rdataA,
    input  logic [31:0]    rdataB,
    input  logic           rfWe,
    input  logic [4:0]     rfWaddr,
    input  logic [31:0]    rfWdata,
    input  logic           exStall,
    input  logic [4:0]     exBusyDest,
    input  logic           exBusyWrite,
    output logic           exValid,
    output corePkg::aluOpT exAluOp,
    output corePkg::aSelT  exASel,
    output corePkg::bSelT  exBSel,
    output logic [31:0]    exRsVal,
    output logic [31:0]    exRtVal,
    output logic [4:0]     exShamt,
    output logic [15:0]    exImm,
    output logic [4:0]     exDest,
    output logic           exWrite,
    output logic           exIllegal
);
    import corePkg::*;

    logic [31:0]            queue [INSTR_CREDITS];
    logic [INSTR_PTR_W-1:0] wrPtr;
    logic [INSTR_PTR_W-1:0] rdPtr;
    logic [INSTR_CNT_W-1:0] count;
    logic [31:0]            headWord;
    logic                   headValid;
    logic                   headNop;
    logic                   hazardStall;
    logic                   pop;
    logic [4:0]             rs;
    logic [4:0]             rt;
    logic [4:0]             rd;
    destSelT                destSel;
    logic                   regWrite;
    logic [1:0]             tuseRs;
    logic [1:0]             tuseRt;

    always_ff @(posedge clk) begin
        if (instrValid) begin
            queue[wrPtr] <= instrWord;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            instrCredit <= 1'b0;
        end else begin
            if (instrValid) begin
                wrPtr <= wrPtr + INSTR_PTR_W'(1);
            end
            if (pop) begin
                rdPtr <= rdPtr + INSTR_PTR_W'(1);
            end
            count       <= count + INSTR_CNT_W'(instrValid) - INSTR_CNT_W'(pop);
            instrCredit <= pop;
        end
    end

    assign headWord  = queue[rdPtr];
    assign headValid = (count != '0);
    assign rs        = headWord[25:21];
    assign rt        = headWord[20:16];
    assign rd        = headWord[15:11];

    instrDecoder i_instrDecoder (
        .instrWord (headWord),
        .aluOp     (exAluOp),
        .aSel      (exASel),
        .bSel      (exBSel),
        .destSel   (destSel),
        .regWrite  (regWrite),
        .tuseRs    (tuseRs),
        .tuseRt    (tuseRt),
        .illegal   (exIllegal)
    );

    assign headNop = (exAluOp == aluNone) && !exIllegal;

    // value from execute arrives too late for an operand needed at once
    always_comb begin
        hazardStall = 1'b0;
        if (headValid && exBusyWrite && exBusyDest != 5'd0) begin
            if (exBusyDest == rs && tuseRs < TNEW_EX) begin
                hazardStall = 1'b1;
            end
            if (exBusyDest == rt && tuseRt < TNEW_EX) begin
                hazardStall = 1'b1;
            end
        end
    end

    assign raddrA  = rs;
    assign raddrB  = rt;
    // bypass the write retiring this cycle
    assign exRsVal = (rfWe && rfWaddr == rs && rs != 5'd0) ? rfWdata : rdataA;
    assign exRtVal = (rfWe && rfWaddr == rt && rt != 5'd0) ? rfWdata : rdataB;
    assign exShamt = headWord[10:6];
    assign exImm   = headWord[15:0];
    assign exWrite = regWrite;
    assign exDest  = !regWrite ? 5'd0 : (destSel == destRd) ? rd : rt;

    assign exValid = headValid && !headNop && !hazardStall;
    // nops leave the queue without a slot in execute
    assign pop     = headValid && (headNop || (!hazardStall && !exStall));

    queueNoOverflow: assert property (
        @(posedge clk) disable iff (!arstN)
        instrValid |-> count < INSTR_CNT_W'(INSTR_CREDITS)
    );

    stalledHeadHeld: assert property (
        @(posedge clk) disable iff (!arstN)
        (headValid && !headNop && (hazardStall || exStall)) |=> $stable(headWord)
    );

endmodule

/* logic/regFile.sv */
module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdataA,
    output logic [31:0] rdataB
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero regardless of contents
    assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

    writeAddrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        we |-> !$isunknown(waddr)
    );

endmodule

/* logic/instrDecoder.sv */
module instrDecoder (
    input  logic [31:0]      instrWord,
    output corePkg::aluOpT   aluOp,
    output corePkg::aSelT    aSel,
    output corePkg::bSelT    bSel,
    output corePkg::destSelT destSel,
    output logic             regWrite,
    output logic [1:0]       tuseRs,
    output logic [1:0]       tuseRt,
    output logic             illegal
);
    import corePkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       known;

    assign opcode = instrWord[31:26];
    assign funct  = instrWord[5:0];

    always_comb begin
        aluOp   = aluNone;
        aSel    = aSelRs;
        bSel    = bSelRt;
        destSel = destRd;
        tuseRs  = TUSE_NONE;
        tuseRt  = TUSE_NONE;
        known   = 1'b1;
        // all-zero word falls through as nop
        if (instrWord != 32'd0) begin
            case (opcode)
                opSpecial: begin
                    case (funct)
                        fnAddu: begin
                            aluOp  = aluAdd;
                            tuseRs = TUSE_EX;
                            tuseRt = TUSE_EX;
                        end
                        fnSubu: begin
                            aluOp  = aluSub;
                            tuseRs = TUSE_EX;
                            tuseRt = TUSE_EX;
                        end
                        fnSll: begin
                            // rt shifted by shamt, rs unused
                            aluOp  = aluSll;
                            aSel   = aSelShamt;
                            tuseRt = TUSE_EX;
                        end
                        fnSlt: begin
                            aluOp  = aluSlt;
                            tuseRs = TUSE_EX;
                            tuseRt = TUSE_EX;
                        end
                        default: begin
                            known = 1'b0;
                        end
                    endcase
                end
                opOri: begin
                    aluOp   = aluOr;
                    bSel    = bSelImm;
                    destSel = destRt;
                    tuseRs  = TUSE_EX;
                end
                opLui: begin
                    aluOp   = aluLui;
                    bSel    = bSelImm;
                    destSel = destRt;
                end
                default: begin
                    known = 1'b0;
                end
            endcase
        end
    end

    // illegal words keep aluNone, so they never write
    assign regWrite = (aluOp != aluNone);
    assign illegal  = !known;

endmodule

/* logic/corePkg.sv */
package corePkg;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opOri     = 6'h0d,
        opLui     = 6'h0f
    } opcodeT;

    // function field of the special opcode, bits 5:0
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        aluNone,
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluOr,
        aluLui
    } aluOpT;

    typedef enum logic {
        aSelRs,
        aSelShamt
    } aSelT;

    typedef enum logic {
        bSelRt,
        bSelImm
    } bSelT;

    typedef enum logic {
        destRd,
        destRt
    } destSelT;

    // use and new-value times, in cycles from issue
    localparam logic [1:0] TUSE_NONE = 2'd3;
    localparam logic [1:0] TUSE_EX   = 2'd0;
    localparam logic [1:0] TNEW_EX   = 2'd1;

    // issue queue depth equals the sender's starting credits
    localparam int INSTR_CREDITS = 4;
    localparam int INSTR_PTR_W   = $clog2(INSTR_CREDITS);
    localparam int INSTR_CNT_W   = $clog2(INSTR_CREDITS + 1);

    localparam int RES_CREDITS = 2;
    localparam int RES_CNT_W   = $clog2(RES_CREDITS + 1);

endpackage
